// File: Bender.yml
package:
  name: fix_engine

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fix_pkg.sv
      - rtl/fix_parser.sv
      - rtl/rx_msg_processor.sv
      - rtl/session_manager.sv
      - rtl/msg_builder.sv
      - rtl/fix_engine.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/fix_engine_checker.sv
      - test/fix_engine_tb.sv

// File: fix_engine.f
+incdir+rtl
rtl/fix_pkg.sv
rtl/fix_parser.sv
rtl/rx_msg_processor.sv
rtl/session_manager.sv
rtl/msg_builder.sv
rtl/fix_engine.sv
test/fix_engine_checker.sv
test/fix_engine_tb.sv

// File: rtl/fix_consts.svh
////////////////////////////////////////////////////////////////////////////
// protocol and timer constants for the FIX session engine
// include wherever the delimiter, field sizes or heartbeat interval are used
////////////////////////////////////////////////////////////////////////////
`ifndef FIX_CONSTS_SVH
`define FIX_CONSTS_SVH

// field delimiter between tag=value pairs
`define FIX_SOH         8'h01

`define FIX_VAL_BYTES   8           // value bytes kept per field
`define FIX_SEQ_DIGITS  4           // outgoing seq num, zero padded ascii

// idle clock cycles before a heartbeat goes out
`define FIX_HB_INTERVAL 2000

`define FIX_BEGIN_STR   "FIX.4.2"   // BeginString value, 7 bytes

`endif

// File: rtl/fix_engine.sv
////////////////////////////////////////////////////////////////////////////
// top of the single link FIX engine, TOE bytes in and reply bytes to FIFO
// parser, rx processor, session manager and builder in a chain
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fix_engine (
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire [7:0]  rx_byte_i,         // from toe
	input  wire        rx_valid_i,
	input  wire        connected_i,       // from toe
	input  wire        end_session_i,     // from app
	input  wire        fifo_full_i,
	output logic       fifo_write_o,
	output logic [7:0] message_o,         // goes to fifo
	output logic       end_o,
	output logic       session_active_o
);

	import fix_pkg::*;

	fix_field_t  field;
	logic        field_valid;
	logic [7:0]  rx_sum;
	rx_summary_t summary;
	logic        summary_valid;
	fix_seq_t    expected_seq;
	logic        tx_start;
	fix_msg_e    tx_type;
	fix_seq_t    tx_seq;
	logic        tx_busy;

	fix_parser i_parser (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.rx_byte_i     (rx_byte_i),
		.rx_valid_i    (rx_valid_i),
		.field_o       (field),
		.field_valid_o (field_valid),
		.rx_sum_o      (rx_sum)
	);

	rx_msg_processor i_rx_proc (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.field_i         (field),
		.field_valid_i   (field_valid),
		.rx_sum_i        (rx_sum),
		.expected_seq_i  (expected_seq),
		.summary_o       (summary),
		.summary_valid_o (summary_valid)
	);

	session_manager i_session (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.connected_i      (connected_i),
		.end_session_i    (end_session_i),
		.summary_i        (summary),
		.summary_valid_i  (summary_valid),
		.tx_busy_i        (tx_busy),
		.expected_seq_o   (expected_seq),
		.tx_start_o       (tx_start),
		.tx_type_o        (tx_type),
		.tx_seq_o         (tx_seq),
		.session_active_o (session_active_o)
	);

	msg_builder i_builder (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.tx_start_i   (tx_start),
		.tx_type_i    (tx_type),
		.tx_seq_i     (tx_seq),
		.fifo_full_i  (fifo_full_i),
		.tx_busy_o    (tx_busy),
		.fifo_write_o (fifo_write_o),
		.message_o    (message_o),
		.end_o        (end_o)
	);

endmodule

`default_nettype wire

// File: rtl/fix_parser.sv
////////////////////////////////////////////////////////////////////////////
// splits the TOE byte stream into tag=value fields, one pulse per field
// also sums the message bytes ahead of the checksum tag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fix_consts.svh"

module fix_parser (
	input  wire                  clk,
	input  wire                  arst_n_i,
	input  wire [7:0]            rx_byte_i,        // from toe
	input  wire                  rx_valid_i,       // one byte per strobe
	output fix_pkg::fix_field_t  field_o,
	output logic                 field_valid_o,    // one cycle per field
	output logic [7:0]           rx_sum_o          // sum before "10="
);

	localparam logic [7:0] CH_EQ   = 8'h3d;       // '='
	localparam logic [7:0] CH_ZERO = 8'h30;       // '0'

	logic                        in_val_q;         // 0 tag, 1 value
	logic [15:0]                 tag_q;            // tag built in decimal
	logic [8*`FIX_VAL_BYTES-1:0] val_q;
	logic [3:0]                  len_q;
	logic [7:0]                  sum_q;            // running byte sum
	logic [7:0]                  base_q;           // sum at field start
	logic [7:0]                  sum_nxt;
	logic                        is_soh;

	assign sum_nxt = sum_q + rx_byte_i;
	assign is_soh  = (rx_byte_i == `FIX_SOH);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			in_val_q      <= 1'b0;
			tag_q         <= '0;
			len_q         <= '0;
			sum_q         <= '0;
			base_q        <= '0;
			field_valid_o <= 1'b0;
		end else begin
			field_valid_o <= 1'b0;
			if (rx_valid_i) begin
				sum_q <= sum_nxt;
				if (!in_val_q) begin
					if (rx_byte_i == CH_EQ) begin
						in_val_q <= 1'b1;   // tag done
						len_q    <= '0;
					end else if (is_soh) begin
						tag_q <= '0;        // stray delimiter
					end else begin
						tag_q <= tag_q * 16'd10 + {8'd0, rx_byte_i - CH_ZERO};
					end
				end else if (is_soh) begin
					in_val_q      <= 1'b0;
					tag_q         <= '0;
					field_valid_o <= 1'b1;
					if (tag_q == 16'd10) begin
						sum_q  <= '0;       // next message starts clean
						base_q <= '0;
					end else begin
						base_q <= sum_nxt;
					end
				end else if (len_q < `FIX_VAL_BYTES) begin
					len_q <= len_q + 4'd1;  // extra bytes dropped
				end
			end
		end
	end

	// value bytes and outputs, no reset needed
	always_ff @(posedge clk) begin
		if (rx_valid_i) begin
			if (!in_val_q && rx_byte_i == CH_EQ) begin
				val_q <= '0;
				if (tag_q == 16'd10)
					rx_sum_o <= base_q;     // checksum tag begins
			end
			if (in_val_q && !is_soh && len_q < `FIX_VAL_BYTES)
				val_q <= {val_q[8*`FIX_VAL_BYTES-9:0], rx_byte_i};
			if (in_val_q && is_soh) begin
				field_o.tag <= tag_q;
				field_o.val <= val_q;
				field_o.len <= len_q;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fix_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the FIX engine: decoded fields, rx summaries, msg types
// import inside module bodies, use scoped names in port lists
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "fix_consts.svh"

package fix_pkg;

	// ascii codes as carried in tag 35
	typedef enum logic [7:0] {
		MSG_NONE      = 8'h00,          // unknown or missing type
		MSG_HEARTBEAT = 8'h30,          // '0'
		MSG_TEST_REQ  = 8'h31,          // '1'
		MSG_LOGOUT    = 8'h35,          // '5'
		MSG_LOGON     = 8'h41           // 'A'
	} fix_msg_e;

	typedef logic [13:0] fix_seq_t;

	// one tag=value pair off the wire
	typedef struct packed {
		logic [15:0]                 tag;   // decimal tag, binary
		logic [8*`FIX_VAL_BYTES-1:0] val;   // raw bytes, last one in lsb
		logic [3:0]                  len;   // valid bytes in val
	} fix_field_t;

	typedef struct packed {
		fix_msg_e msg_type;
		fix_seq_t seq_num;
		logic     seq_ok;                   // matches expected seq
		logic     chk_ok;                   // checksum field matches sum
	} rx_summary_t;

endpackage

`default_nettype wire

// File: rtl/msg_builder.sv
////////////////////////////////////////////////////////////////////////////
// serializes one reply per start pulse into the outgoing FIFO
// fixed template with BodyLength and CheckSum, stalls while FIFO is full
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fix_consts.svh"

module msg_builder (
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    tx_start_i,        // from session mgr
	input  wire fix_pkg::fix_msg_e tx_type_i,
	input  wire fix_pkg::fix_seq_t tx_seq_i,
	input  wire                    fifo_full_i,       // back-pressure level
	output logic                   tx_busy_o,
	output logic                   fifo_write_o,
	output logic [7:0]             message_o,         // goes to fifo
	output logic                   end_o              // last byte of reply
);

	import fix_pkg::*;

	// byte positions in 8=FIX.4.2|9=LLL|35=T|34=NNNN|10=CCC|
	localparam int P_BEGIN   = 2;
	localparam int P_LEN     = 12;
	localparam int P_TYPE    = 19;
	localparam int P_SEQ     = 24;
	localparam int P_SEQ_END = P_SEQ + `FIX_SEQ_DIGITS;  // soh closing body
	localparam int P_CHK     = P_SEQ_END + 4;
	localparam int P_LAST    = P_CHK + 3;
	localparam int BODY_LEN  = P_SEQ_END - P_TYPE + 4;   // "35=" through soh

	localparam logic [55:0] BEGIN_STR = `FIX_BEGIN_STR;
	localparam logic [23:0] LEN_STR   = {8'h30 + 8'(BODY_LEN / 100),
	                                     8'h30 + 8'((BODY_LEN / 10) % 10),
	                                     8'h30 + 8'(BODY_LEN % 10)};

	logic       busy_q;
	logic [5:0] idx_q;                                    // template position
	logic [7:0] chk_q;                                    // sum of sent bytes
	fix_msg_e   type_q;
	fix_seq_t   seq_q;
	logic [7:0] seq_dig [`FIX_SEQ_DIGITS];
	logic [23:0] chk_str;

	always_comb begin : seq_ascii
		fix_seq_t rem;
		rem = seq_q;
		for (int i = `FIX_SEQ_DIGITS - 1; i >= 0; i--) begin
			seq_dig[i] = 8'h30 + 8'(rem % fix_seq_t'(10));
			rem        = rem / fix_seq_t'(10);
		end
	end

	assign chk_str = {8'h30 + chk_q / 8'd100,
	                  8'h30 + (chk_q / 8'd10) % 8'd10,
	                  8'h30 + chk_q % 8'd10};

	always_comb begin
		case (idx_q) inside
			6'd0:                            message_o = "8";
			6'd1, 6'd11, P_TYPE - 1,
			P_SEQ - 1, P_CHK - 1:            message_o = "=";
			[P_BEGIN:P_BEGIN + 6]:           message_o = BEGIN_STR[8*(P_BEGIN + 6 - idx_q) +: 8];
			6'd10:                           message_o = "9";
			[P_LEN:P_LEN + 2]:               message_o = LEN_STR[8*(P_LEN + 2 - idx_q) +: 8];
			P_TYPE - 3, P_SEQ - 3:           message_o = "3";
			P_TYPE - 2:                      message_o = "5";
			P_TYPE:                          message_o = type_q;
			P_SEQ - 2:                       message_o = "4";
			[P_SEQ:P_SEQ_END - 1]:           message_o = seq_dig[idx_q - P_SEQ];
			P_CHK - 3:                       message_o = "1";
			P_CHK - 2:                       message_o = "0";
			[P_CHK:P_CHK + 2]:               message_o = chk_str[8*(P_CHK + 2 - idx_q) +: 8];
			default:                         message_o = `FIX_SOH;
		endcase
	end

	assign tx_busy_o    = busy_q;
	assign fifo_write_o = busy_q && !fifo_full_i;         // hold while full
	assign end_o        = fifo_write_o && (idx_q == 6'(P_LAST));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			idx_q  <= '0;
			chk_q  <= '0;
		end else if (tx_start_i) begin
			busy_q <= 1'b1;
			idx_q  <= '0;
			chk_q  <= '0;
		end else if (fifo_write_o) begin
			if (idx_q <= 6'(P_SEQ_END))
				chk_q <= chk_q + message_o;               // bytes ahead of "10="
			if (end_o) begin
				busy_q <= 1'b0;
				idx_q  <= '0;
			end else begin
				idx_q <= idx_q + 6'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx_start_i) begin
			type_q <= tx_type_i;
			seq_q  <= tx_seq_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rx_msg_processor.sv
////////////////////////////////////////////////////////////////////////////
// gathers MsgType, MsgSeqNum and CheckSum of each received message
// emits one summary per message when the checksum field closes it
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fix_consts.svh"

module rx_msg_processor (
	input  wire                   clk,
	input  wire                   arst_n_i,
	input  wire fix_pkg::fix_field_t field_i,         // from parser
	input  wire                   field_valid_i,
	input  wire [7:0]             rx_sum_i,           // computed sum
	input  wire fix_pkg::fix_seq_t expected_seq_i,    // from session mgr
	output fix_pkg::rx_summary_t  summary_o,
	output logic                  summary_valid_o
);

	import fix_pkg::*;

	fix_msg_e    type_q;
	fix_seq_t    seq_q;
	logic [15:0] val_bin;                             // value as a number

	// ascii decimal digits to binary, first byte most significant
	function automatic logic [15:0] dec_to_bin(input logic [8*`FIX_VAL_BYTES-1:0] val,
	                                           input logic [3:0] len);
		logic [15:0] acc;
		acc = '0;
		for (int i = `FIX_VAL_BYTES - 1; i >= 0; i--) begin
			if (i < len)
				acc = acc * 16'd10 + {8'd0, val[8*i +: 8] - 8'h30};
		end
		return acc;
	endfunction

	assign val_bin = dec_to_bin(field_i.val, field_i.len);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			type_q          <= MSG_NONE;
			seq_q           <= '0;
			summary_valid_o <= 1'b0;
		end else begin
			summary_valid_o <= 1'b0;
			if (field_valid_i) begin
				case (field_i.tag)
					16'd35: begin
						case (field_i.val[7:0])
							8'h41:   type_q <= MSG_LOGON;
							8'h30:   type_q <= MSG_HEARTBEAT;
							8'h31:   type_q <= MSG_TEST_REQ;
							8'h35:   type_q <= MSG_LOGOUT;
							default: type_q <= MSG_NONE;
						endcase
						if (field_i.len != 4'd1)
							type_q <= MSG_NONE;   // multi char types unsupported
					end
					16'd34: seq_q <= val_bin[13:0];
					16'd10: begin
						summary_valid_o <= 1'b1;
						type_q          <= MSG_NONE;  // ready for next msg
						seq_q           <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid_i && field_i.tag == 16'd10) begin
			summary_o.msg_type <= type_q;
			summary_o.seq_num  <= seq_q;
			summary_o.seq_ok   <= (seq_q == expected_seq_i);
			summary_o.chk_ok   <= (val_bin == {8'd0, rx_sum_i}) && (field_i.len == 4'd3);
		end
	end

endmodule

`default_nettype wire

// File: rtl/session_manager.sv
////////////////////////////////////////////////////////////////////////////
// logon state, sequence numbers and heartbeat timer of one FIX session
// picks the reply for each accepted message, one request held if busy
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fix_consts.svh"

module session_manager (
	input  wire                    clk,
	input  wire                    arst_n_i,
	input  wire                    connected_i,        // link up at toe
	input  wire                    end_session_i,      // from app
	input  wire fix_pkg::rx_summary_t summary_i,
	input  wire                    summary_valid_i,
	input  wire                    tx_busy_i,          // builder level
	output fix_pkg::fix_seq_t      expected_seq_o,
	output logic                   tx_start_o,
	output fix_pkg::fix_msg_e      tx_type_o,
	output fix_pkg::fix_seq_t      tx_seq_o,
	output logic                   session_active_o
);

	import fix_pkg::*;

	localparam int HB_W = $clog2(`FIX_HB_INTERVAL + 1);

	logic            active_q;
	fix_seq_t        exp_seq_q;
	fix_seq_t        out_seq_q;
	logic [HB_W-1:0] hb_cnt_q;
	logic            pend_q;                           // slot occupied
	fix_msg_e        pend_type_q;
	fix_seq_t        pend_seq_q;
	logic            accept;
	logic            hb_due;
	logic            req_v;
	fix_msg_e        req_type;
	logic            go_active;
	logic            go_idle;
	logic            tx_free;                          // builder can take one
	logic            req_drop;

	assign accept   = summary_valid_i && summary_i.seq_ok && summary_i.chk_ok && connected_i;
	assign hb_due   = active_q && (hb_cnt_q == HB_W'(`FIX_HB_INTERVAL));
	assign tx_free  = !tx_busy_i && !tx_start_o;      // busy lags start by one
	assign req_drop = req_v && pend_q && !tx_free;

	// one request per cycle, received traffic first
	always_comb begin
		req_v     = 1'b0;
		req_type  = MSG_NONE;
		go_active = 1'b0;
		go_idle   = 1'b0;
		if (accept) begin
			case (summary_i.msg_type)
				MSG_LOGON: if (!active_q) begin
					req_v     = 1'b1;
					req_type  = MSG_LOGON;
					go_active = 1'b1;
				end
				MSG_TEST_REQ: if (active_q) begin
					req_v    = 1'b1;
					req_type = MSG_HEARTBEAT;
				end
				MSG_LOGOUT: if (active_q) begin
					req_v    = 1'b1;
					req_type = MSG_LOGOUT;
					go_idle  = 1'b1;
				end
				default: ;                                 // heartbeat, no reply
			endcase
		end else if (end_session_i && active_q) begin
			req_v    = 1'b1;
			req_type = MSG_LOGOUT;
			go_idle  = 1'b1;
		end else if (hb_due) begin
			req_v    = 1'b1;
			req_type = MSG_HEARTBEAT;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			active_q   <= 1'b0;
			exp_seq_q  <= fix_seq_t'(1);
			out_seq_q  <= fix_seq_t'(1);
			hb_cnt_q   <= '0;
			pend_q     <= 1'b0;
			tx_start_o <= 1'b0;
		end else begin
			tx_start_o <= tx_free && (pend_q || req_v);
			if (pend_q && tx_free)
				pend_q <= req_v;                           // slot refilled
			else if (req_v && !tx_free)
				pend_q <= 1'b1;
			if (accept)
				exp_seq_q <= exp_seq_q + fix_seq_t'(1);
			if (req_v && !req_drop)
				out_seq_q <= out_seq_q + fix_seq_t'(1);
			if (go_active)
				active_q <= 1'b1;
			if (go_idle) begin
				active_q  <= 1'b0;
				exp_seq_q <= fix_seq_t'(1);
				out_seq_q <= fix_seq_t'(1);
			end
			if (!active_q || accept || tx_start_o || hb_due)
				hb_cnt_q <= '0;
			else
				hb_cnt_q <= hb_cnt_q + 1'b1;
		end
	end

	// request payload, pending first
	always_ff @(posedge clk) begin
		if (tx_free) begin
			tx_type_o <= pend_q ? pend_type_q : req_type;
			tx_seq_o  <= pend_q ? pend_seq_q : out_seq_q;
		end
		if (req_v && (pend_q == tx_free)) begin
			pend_type_q <= req_type;
			pend_seq_q  <= out_seq_q;
		end
	end

	assign expected_seq_o   = exp_seq_q;
	assign session_active_o = active_q;

endmodule

`default_nettype wire

// File: test/fix_engine_checker.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the FIFO side and session output of fix_engine
// bound into fix_engine below, failures counted for the testbench
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fix_engine_checker (
	input wire       clk,
	input wire       arst_n_i,
	input wire       fifo_full_i,
	input wire       fifo_write_i,
	input wire [7:0] message_i,
	input wire       end_i,
	input wire       session_active_i
);

	int unsigned fail_cnt = 0;                       // read by testbench at end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		fifo_full_i |-> !fifo_write_i)
	else begin
		$error("fifo write while fifo full");
		fail_cnt++;
	end

	a_end_with_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		end_i |-> fifo_write_i)
	else begin
		$error("end marker without a fifo write");
		fail_cnt++;
	end

	a_known_byte: assert property (@(posedge clk) disable iff (!arst_n_i)
		fifo_write_i |-> !$isunknown(message_i))
	else begin
		$error("unknown byte written to fifo");
		fail_cnt++;
	end

	// outputs quiet on the first edge out of reset
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n_i) |-> !fifo_write_i && !end_i && !session_active_i)
	else begin
		$error("fifo or session output active right after reset");
		fail_cnt++;
	end

endmodule

bind fix_engine fix_engine_checker i_checker (
	.clk              (clk),
	.arst_n_i         (arst_n_i),
	.fifo_full_i      (fifo_full_i),
	.fifo_write_i     (fifo_write_o),
	.message_i        (message_o),
	.end_i            (end_o),
	.session_active_i (session_active_o)
);

`default_nettype wire

// File: test/fix_engine_tb.sv
////////////////////////////////////////////////////////////////////////////
// seeded random testbench for fix_engine against a session model
// checks every reply byte, end marker and logon state, watchdog bounded
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "fix_consts.svh"

module fix_engine_tb;

	import fix_pkg::*;

	localparam int CLK_NS     = 8;
	localparam int REPLY_LEN  = 36;                 // 10 + 6 + 5 + 8 + 7 bytes
	localparam int TYPE_POS   = 19;                 // byte after "35="
	localparam int N_RANDOM   = 32;                 // random rounds
	localparam int N_MSG      = 2 * N_RANDOM + 12;  // most messages sent
	localparam int WD_NS      = N_MSG * (REPLY_LEN + `FIX_HB_INTERVAL) * CLK_NS * 4;
	localparam int QUIET      = 24;                 // idle cycles after each action
	localparam int REPLY_WAIT = 8 * REPLY_LEN;

	logic       clk;
	logic       arst_n;
	logic [7:0] rx_byte;
	logic       rx_valid;
	logic       connected;
	logic       end_session;
	logic       fifo_full;
	logic       fifo_write;
	logic [7:0] message;
	logic       msg_end;
	logic       session_active;

	integer     seed = 32'h143b;
	logic [7:0] build_q[$];                         // frame being assembled
	logic [7:0] exp_bytes[$];                       // expected reply stream
	bit         exp_last[$];
	fix_msg_e   exp_types[$];
	int         out_pos = 0;                        // byte index in current reply
	int         bytes_seen = 0;
	bit         active_m;                           // session model
	int         exp_seq_m;
	int         out_seq_m;

	fix_engine i_dut (
		.clk              (clk),
		.arst_n_i         (arst_n),
		.rx_byte_i        (rx_byte),
		.rx_valid_i       (rx_valid),
		.connected_i      (connected),
		.end_session_i    (end_session),
		.fifo_full_i      (fifo_full),
		.fifo_write_o     (fifo_write),
		.message_o        (message),
		.end_o            (msg_end),
		.session_active_o (session_active)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s got 0x%h expected 0x%h at %0t",
				name, got, exp, $time));
	endtask

	task automatic check_type(input string name, input fix_msg_e got, input fix_msg_e exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s type got 0x%h (%s) expected 0x%h (%s)",
				name, got, got.name(), exp, exp.name()));
	endtask

	task automatic check_active(input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH session_active_o got 0x%h expected 0x%h at %0t",
				got, exp, $time));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH %s got 0x%h expected 0x%h at %0t",
				name, got, exp, $time));
	endtask

	// one clock, fifo back-pressure redrawn each edge
	task automatic step();
		@(posedge clk);
		fifo_full <= ($unsigned($random(seed)) % 4) == 0;
	endtask

	task automatic push_text(input string s);
		for (int i = 0; i < s.len(); i++)
			build_q.push_back(s[i]);
	endtask

	// decimal ascii, w digits zero padded, or as few as needed if w is 0
	task automatic push_num(input int v, input int w);
		int n;
		int p;
		n = (w > 0) ? w : 1;
		p = v;
		while (w == 0 && p >= 10) begin
			p = p / 10;
			n++;
		end
		for (int i = n - 1; i >= 0; i--) begin
			p = v;
			for (int k = 0; k < i; k++)
				p = p / 10;
			build_q.push_back(8'h30 + 8'(p % 10));
		end
	endtask

	// 8=FIX.4.2|9=len|35=T|34=seq|10=sum|, chk_adj corrupts the sum
	task automatic frame_msg(input fix_msg_e t, input int seq, input int seq_w,
	                         input int len_w, input int chk_adj);
		logic [7:0] body[$];
		int         sum;
		build_q.delete();
		push_text("35=");
		build_q.push_back(t);
		build_q.push_back(`FIX_SOH);
		push_text("34=");
		push_num(seq, seq_w);
		build_q.push_back(`FIX_SOH);
		body = build_q;                             // length counts this part
		build_q.delete();
		push_text("8=");
		push_text(`FIX_BEGIN_STR);
		build_q.push_back(`FIX_SOH);
		push_text("9=");
		push_num(body.size(), len_w);
		build_q.push_back(`FIX_SOH);
		foreach (body[i])
			build_q.push_back(body[i]);
		sum = chk_adj;
		foreach (build_q[i])
			sum += build_q[i];
		push_text("10=");
		push_num(sum % 256, 3);
		build_q.push_back(`FIX_SOH);
	endtask

	task automatic expect_reply(input fix_msg_e t, input int seq);
		frame_msg(t, seq, `FIX_SEQ_DIGITS, 3, 0);
		foreach (build_q[i]) begin
			exp_bytes.push_back(build_q[i]);
			exp_last.push_back(i == build_q.size() - 1);
		end
		exp_types.push_back(t);
	endtask

	task automatic logout_reset();
		active_m  = 1'b0;
		exp_seq_m = 1;
		out_seq_m = 1;
	endtask

	// accepted message, reply chosen from logon state
	task automatic model_rx(input fix_msg_e t);
		exp_seq_m++;
		case (t)
			MSG_LOGON: if (!active_m) begin
				expect_reply(MSG_LOGON, out_seq_m);
				out_seq_m++;
				active_m = 1'b1;
			end
			MSG_TEST_REQ: if (active_m) begin
				expect_reply(MSG_HEARTBEAT, out_seq_m);
				out_seq_m++;
			end
			MSG_LOGOUT: if (active_m) begin
				expect_reply(MSG_LOGOUT, out_seq_m);
				logout_reset();
			end
			default: ;                                  // heartbeat, no reply
		endcase
	endtask

	task automatic send_frame();
		int gap;
		foreach (build_q[i]) begin
			gap = $unsigned($random(seed)) % 4;
			rx_valid <= 1'b0;
			repeat (gap) step();
			rx_valid <= 1'b1;
			rx_byte  <= build_q[i];
			step();
		end
		rx_valid <= 1'b0;
	endtask

	task automatic wait_replies();
		int n;
		n = 0;
		while (exp_bytes.size() != 0) begin
			step();
			n++;
			if (n > REPLY_WAIT)
				stop_on_error("reply bytes still missing after the wait limit");
		end
		repeat (QUIET) step();
	endtask

	task automatic check_session();
		@(negedge clk);
		check_active(session_active, active_m);
		step();
	endtask

	// how: 0 valid, 1 bad checksum, 2 bad seq num, 3 link down
	task automatic rx_msg(input fix_msg_e t, input int how);
		int seq;
		int adj;
		seq = exp_seq_m;
		adj = 0;
		if (how == 1)
			adj = 1 + $unsigned($random(seed)) % 255;
		if (how == 2)
			seq = exp_seq_m + 1 + $unsigned($random(seed)) % 3;
		if (how == 0)
			model_rx(t);
		frame_msg(t, seq, 0, 0, adj);
		if (how == 3)
			connected <= 1'b0;
		send_frame();
		wait_replies();
		connected <= 1'b1;
		check_session();
	endtask

	// follow-up reply proves the expected seq num did not move
	task automatic bad_msg(input fix_msg_e t);
		rx_msg(t, 1 + $unsigned($random(seed)) % 3);
		rx_msg(active_m ? MSG_TEST_REQ : MSG_LOGON, 0);
	endtask

	task automatic idle_heartbeat();
		int n;
		int seen;
		expect_reply(MSG_HEARTBEAT, out_seq_m);
		out_seq_m++;
		n    = 0;
		seen = bytes_seen;
		while (bytes_seen == seen) begin
			step();
			n++;
			if (n > `FIX_HB_INTERVAL + 40)
				stop_on_error("no heartbeat sent within the interval after the last activity");
		end
		wait_replies();
		check_session();
	endtask

	task automatic app_logout();
		if (active_m) begin
			expect_reply(MSG_LOGOUT, out_seq_m);
			logout_reset();
		end
		end_session <= 1'b1;
		step();
		end_session <= 1'b0;
		wait_replies();
		check_session();
	endtask

	function automatic fix_msg_e pick_type();
		case ($unsigned($random(seed)) % 4)
			0:       return MSG_LOGON;
			1:       return MSG_HEARTBEAT;
			2:       return MSG_TEST_REQ;
			default: return MSG_LOGOUT;
		endcase
	endfunction

	// reply monitor, outputs settled at the falling edge
	always @(negedge clk) begin
		if (arst_n && fifo_write) begin
			if (exp_bytes.size() == 0) begin
				stop_on_error($sformatf("reply byte 0x%h written with no reply pending", message));
			end else begin
				if (out_pos == TYPE_POS)
					check_type("message_o", fix_msg_e'(message), exp_types[0]);
				check_byte("message_o", message, exp_bytes.pop_front());
				check_flag("end_o", msg_end, exp_last.pop_front());
				if (msg_end) begin
					out_pos = 0;
					void'(exp_types.pop_front());
				end else begin
					out_pos++;
				end
				bytes_seen++;
			end
		end
	end

	initial begin
		#(WD_NS);
		stop_on_error("watchdog expired before the tests finished");
	end

	initial begin
		int r;
		clk         = 1'b0;
		arst_n      = 1'b0;
		rx_byte     = 8'h00;
		rx_valid    = 1'b0;
		connected   = 1'b1;
		end_session = 1'b0;
		fifo_full   = 1'b0;
		active_m    = 1'b0;
		exp_seq_m   = 1;
		out_seq_m   = 1;
		repeat (10) step();
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("fifo_write_o", fifo_write, 1'b0);
		check_active(session_active, 1'b0);
		step();

		rx_msg(MSG_LOGON, 0);                       // logon reply, goes active
		rx_msg(MSG_TEST_REQ, 0);
		rx_msg(MSG_HEARTBEAT, 0);                   // no reply
		rx_msg(MSG_TEST_REQ, 1);                    // bad checksum
		rx_msg(MSG_TEST_REQ, 0);
		rx_msg(MSG_LOGOUT, 2);                      // bad seq num
		rx_msg(MSG_TEST_REQ, 0);
		rx_msg(MSG_TEST_REQ, 3);                    // link down
		rx_msg(MSG_TEST_REQ, 0);
		idle_heartbeat();
		rx_msg(MSG_LOGOUT, 0);
		rx_msg(MSG_LOGON, 0);                       // seq nums back at 1
		app_logout();

		for (int i = 0; i < N_RANDOM; i++) begin
			r = $unsigned($random(seed)) % 8;
			case (r)
				0, 1, 2: rx_msg(active_m ? pick_type() : MSG_LOGON, 0);
				3, 4:    bad_msg(pick_type());
				5:       rx_msg(MSG_TEST_REQ, 0);
				6: begin
					if (active_m)
						idle_heartbeat();
					else
						rx_msg(MSG_LOGON, 0);
				end
				default: begin
					if (active_m)
						app_logout();
					else
						rx_msg(pick_type(), 0);
				end
			endcase
		end

		if (i_dut.i_checker.fail_cnt != 0) begin
			stop_on_error("checker assertions failed during the run");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
